// File: rvc_pkg.sv
package rvc_pkg;

	// datapath widths.
	localparam int XLEN  = 64;
	localparam int REG_W = 5;

	// fixed architectural registers used by the expansion.
	localparam logic [REG_W-1:0] XREG_ZERO = 5'd0;
	localparam logic [REG_W-1:0] XREG_SP   = 5'd2;

	// micro-op queue geometry.
	localparam int QUEUE_DEPTH = 4;
	localparam int PTR_W       = 2;

	// register block bus widths.
	localparam int AXI_ADDR_W = 4;
	localparam int AXI_DATA_W = 32;

	localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

	// register map, byte offsets.
	localparam logic [AXI_ADDR_W-1:0] REG_CTRL     = 4'h0;
	localparam logic [AXI_ADDR_W-1:0] REG_DECODED  = 4'h4;
	localparam logic [AXI_ADDR_W-1:0] REG_ILLEGAL  = 4'h8;
	localparam logic [AXI_ADDR_W-1:0] REG_LAST_ILL = 4'hc;

	// decode is running out of reset.
	localparam logic CTRL_ENABLE_RST = 1'b1;

	// operation class carried by each micro-op.
	typedef enum logic [3:0] {
		OP_ADD     = 4'd0,
		OP_ADDI    = 4'd1,
		OP_SLLI    = 4'd2,
		OP_LW      = 4'd3,
		OP_LD      = 4'd4,
		OP_SW      = 4'd5,
		OP_SD      = 4'd6,
		OP_JAL     = 4'd7,
		OP_JALR    = 4'd8,
		OP_BEQ     = 4'd9,
		OP_BNE     = 4'd10,
		OP_ILLEGAL = 4'd15
	} uop_op_e;

endpackage

// File: rvc_decoder.sv
module rvc_decoder import rvc_pkg::*; (
	input  logic             enable,
	input  logic             fetch_valid,
	input  logic [15:0]      fetch_instr,
	input  logic [XLEN-1:0]  fetch_pc,
	output logic             fetch_ready,
	input  logic             queue_full,
	output logic             push,
	output logic             illegal,
	output uop_op_e          op,
	output logic [REG_W-1:0] rd,
	output logic [REG_W-1:0] rs1,
	output logic [REG_W-1:0] rs2,
	output logic [XLEN-1:0]  imm,
	output logic [XLEN-1:0]  pc,
	output logic             is_rvc
);

	logic [1:0]       quadrant;
	logic [2:0]       funct3;
	logic [REG_W-1:0] rd_full;
	logic [REG_W-1:0] rs2_full;
	logic [REG_W-1:0] rs1_c;
	logic [REG_W-1:0] rs2_c;

	logic [XLEN-1:0]  imm_ciw;
	logic [XLEN-1:0]  imm_clw;
	logic [XLEN-1:0]  imm_cld;
	logic [XLEN-1:0]  imm_ci;
	logic [XLEN-1:0]  imm_shamt;
	logic [XLEN-1:0]  imm_cj;
	logic [XLEN-1:0]  imm_cb;
	logic [XLEN-1:0]  imm_lwsp;
	logic [XLEN-1:0]  imm_ldsp;
	logic [XLEN-1:0]  imm_swsp;
	logic [XLEN-1:0]  imm_sdsp;

	assign quadrant = fetch_instr[1:0];
	assign funct3   = fetch_instr[15:13];

	// full register fields and the x8..x15 compressed forms.
	assign rd_full  = fetch_instr[11:7];
	assign rs2_full = fetch_instr[6:2];
	assign rs1_c    = {2'b01, fetch_instr[9:7]};
	assign rs2_c    = {2'b01, fetch_instr[4:2]};

	// scaled offsets, all zero extended.
	assign imm_ciw  = {{(XLEN-10){1'b0}}, fetch_instr[10:7], fetch_instr[12:11],
		fetch_instr[5], fetch_instr[6], 2'b00};
	assign imm_clw  = {{(XLEN-7){1'b0}}, fetch_instr[5], fetch_instr[12:10],
		fetch_instr[6], 2'b00};
	assign imm_cld  = {{(XLEN-8){1'b0}}, fetch_instr[6:5], fetch_instr[12:10], 3'b000};
	assign imm_lwsp = {{(XLEN-8){1'b0}}, fetch_instr[3:2], fetch_instr[12],
		fetch_instr[6:4], 2'b00};
	assign imm_ldsp = {{(XLEN-9){1'b0}}, fetch_instr[4:2], fetch_instr[12],
		fetch_instr[6:5], 3'b000};
	assign imm_swsp = {{(XLEN-8){1'b0}}, fetch_instr[8:7], fetch_instr[12:9], 2'b00};
	assign imm_sdsp = {{(XLEN-9){1'b0}}, fetch_instr[9:7], fetch_instr[12:10], 3'b000};

	// six-bit CI forms.
	assign imm_ci    = {{(XLEN-6){fetch_instr[12]}}, fetch_instr[12], fetch_instr[6:2]};
	assign imm_shamt = {{(XLEN-6){1'b0}}, fetch_instr[12], fetch_instr[6:2]};

	// jump and branch offsets are sign extended from bit 12.
	assign imm_cj = {{(XLEN-12){fetch_instr[12]}}, fetch_instr[12], fetch_instr[8],
		fetch_instr[10:9], fetch_instr[6], fetch_instr[7], fetch_instr[2],
		fetch_instr[11], fetch_instr[5:3], 1'b0};
	assign imm_cb = {{(XLEN-9){fetch_instr[12]}}, fetch_instr[12], fetch_instr[6:5],
		fetch_instr[2], fetch_instr[11:10], fetch_instr[4:3], 1'b0};

	always_comb begin
		op  = OP_ILLEGAL;
		rd  = XREG_ZERO;
		rs1 = XREG_ZERO;
		rs2 = XREG_ZERO;
		imm = '0;
		case ({quadrant, funct3})
			// c.addi4spn, zero immediate is reserved.
			5'b00_000: begin
				if (fetch_instr[12:5] != 8'd0) begin
					op  = OP_ADDI;
					rd  = rs2_c;
					rs1 = XREG_SP;
					imm = imm_ciw;
				end
			end
			5'b00_010: begin
				op  = OP_LW;
				rd  = rs2_c;
				rs1 = rs1_c;
				imm = imm_clw;
			end
			5'b00_011: begin
				op  = OP_LD;
				rd  = rs2_c;
				rs1 = rs1_c;
				imm = imm_cld;
			end
			5'b00_110: begin
				op  = OP_SW;
				rs1 = rs1_c;
				rs2 = rs2_c;
				imm = imm_clw;
			end
			5'b00_111: begin
				op  = OP_SD;
				rs1 = rs1_c;
				rs2 = rs2_c;
				imm = imm_cld;
			end
			5'b01_000: begin
				op  = OP_ADDI;
				rd  = rd_full;
				rs1 = rd_full;
				imm = imm_ci;
			end
			// c.li reads x0.
			5'b01_010: begin
				op  = OP_ADDI;
				rd  = rd_full;
				imm = imm_ci;
			end
			5'b01_101: begin
				op  = OP_JAL;
				imm = imm_cj;
			end
			5'b01_110: begin
				op  = OP_BEQ;
				rs1 = rs1_c;
				imm = imm_cb;
			end
			5'b01_111: begin
				op  = OP_BNE;
				rs1 = rs1_c;
				imm = imm_cb;
			end
			5'b10_000: begin
				op  = OP_SLLI;
				rd  = rd_full;
				rs1 = rd_full;
				imm = imm_shamt;
			end
			5'b10_010: begin
				op  = OP_LW;
				rd  = rd_full;
				rs1 = XREG_SP;
				imm = imm_lwsp;
			end
			5'b10_011: begin
				op  = OP_LD;
				rd  = rd_full;
				rs1 = XREG_SP;
				imm = imm_ldsp;
			end
			// c.mv, c.jr and c.add share this slot.
			5'b10_100: begin
				if (!fetch_instr[12] && rs2_full != XREG_ZERO) begin
					op  = OP_ADD;
					rd  = rd_full;
					rs2 = rs2_full;
				end else if (!fetch_instr[12] && rd_full != XREG_ZERO) begin
					op  = OP_JALR;
					rs1 = rd_full;
				end else if (fetch_instr[12] && rs2_full != XREG_ZERO) begin
					op  = OP_ADD;
					rd  = rd_full;
					rs1 = rd_full;
					rs2 = rs2_full;
				end
			end
			5'b10_110: begin
				op  = OP_SW;
				rs1 = XREG_SP;
				rs2 = rs2_full;
				imm = imm_swsp;
			end
			5'b10_111: begin
				op  = OP_SD;
				rs1 = XREG_SP;
				rs2 = rs2_full;
				imm = imm_sdsp;
			end
			// fp, addiw, lui, misc-alu and quadrant 3.
			default: op = OP_ILLEGAL;
		endcase
	end

	assign illegal     = (op == OP_ILLEGAL);
	assign pc          = fetch_pc;
	assign is_rvc      = 1'b1;
	assign fetch_ready = enable & ~queue_full;
	assign push        = fetch_valid & fetch_ready;

endmodule

// File: uop_queue.sv
module uop_queue import rvc_pkg::*; (
	input  logic             CLK,
	input  logic             rst_n,
	input  logic             push,
	input  uop_op_e          op,
	input  logic [REG_W-1:0] rd,
	input  logic [REG_W-1:0] rs1,
	input  logic [REG_W-1:0] rs2,
	input  logic [XLEN-1:0]  imm,
	input  logic [XLEN-1:0]  pc,
	input  logic             is_rvc,
	output logic             full,
	output logic             uop_valid,
	input  logic             uop_ready,
	output uop_op_e          uop_op,
	output logic [REG_W-1:0] uop_rd,
	output logic [REG_W-1:0] uop_rs1,
	output logic [REG_W-1:0] uop_rs2,
	output logic [XLEN-1:0]  uop_imm,
	output logic [XLEN-1:0]  uop_pc,
	output logic             uop_is_rvc
);

	uop_op_e          op_mem  [QUEUE_DEPTH];
	logic [REG_W-1:0] rd_mem  [QUEUE_DEPTH];
	logic [REG_W-1:0] rs1_mem [QUEUE_DEPTH];
	logic [REG_W-1:0] rs2_mem [QUEUE_DEPTH];
	logic [XLEN-1:0]  imm_mem [QUEUE_DEPTH];
	logic [XLEN-1:0]  pc_mem  [QUEUE_DEPTH];
	logic             rvc_mem [QUEUE_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;
	logic             pop;

	assign full      = (count == (PTR_W+1)'(QUEUE_DEPTH));
	assign uop_valid = (count != '0);
	assign pop       = uop_valid & uop_ready;

	// the decoder already checked full before pushing.
	always_ff @(posedge CLK) begin
		if (push) begin
			op_mem[wr_ptr]  <= op;
			rd_mem[wr_ptr]  <= rd;
			rs1_mem[wr_ptr] <= rs1;
			rs2_mem[wr_ptr] <= rs2;
			imm_mem[wr_ptr] <= imm;
			pc_mem[wr_ptr]  <= pc;
			rvc_mem[wr_ptr] <= is_rvc;
		end
	end

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	// head entry, held until popped.
	assign uop_op     = op_mem[rd_ptr];
	assign uop_rd     = rd_mem[rd_ptr];
	assign uop_rs1    = rs1_mem[rd_ptr];
	assign uop_rs2    = rs2_mem[rd_ptr];
	assign uop_imm    = imm_mem[rd_ptr];
	assign uop_pc     = pc_mem[rd_ptr];
	assign uop_is_rvc = rvc_mem[rd_ptr];

endmodule

// File: decode_regs.sv
module decode_regs import rvc_pkg::*; (
	input  logic                  CLK,
	input  logic                  rst_n,
	input  logic [AXI_ADDR_W-1:0] s_axi_awaddr,
	input  logic                  s_axi_awvalid,
	output logic                  s_axi_awready,
	input  logic [AXI_DATA_W-1:0] s_axi_wdata,
	input  logic [3:0]            s_axi_wstrb,
	input  logic                  s_axi_wvalid,
	output logic                  s_axi_wready,
	output logic [1:0]            s_axi_bresp,
	output logic                  s_axi_bvalid,
	input  logic                  s_axi_bready,
	input  logic [AXI_ADDR_W-1:0] s_axi_araddr,
	input  logic                  s_axi_arvalid,
	output logic                  s_axi_arready,
	output logic [AXI_DATA_W-1:0] s_axi_rdata,
	output logic [1:0]            s_axi_rresp,
	output logic                  s_axi_rvalid,
	input  logic                  s_axi_rready,
	input  logic                  push,
	input  logic                  illegal,
	input  logic [15:0]           instr,
	output logic                  enable
);

	logic [AXI_DATA_W-1:0] decoded_cnt;
	logic [AXI_DATA_W-1:0] illegal_cnt;
	logic [15:0]           last_ill;
	logic [AXI_DATA_W-1:0] rd_mux;
	logic                  wr_en;
	logic                  rd_en;

	// address and data are accepted together.
	assign wr_en = s_axi_awready & s_axi_awvalid & s_axi_wvalid;
	assign rd_en = s_axi_arready & s_axi_arvalid;

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			s_axi_awready <= 1'b0;
			s_axi_wready  <= 1'b0;
			s_axi_bvalid  <= 1'b0;
		end else begin
			s_axi_awready <= ~s_axi_awready & ~s_axi_bvalid & s_axi_awvalid & s_axi_wvalid;
			s_axi_wready  <= ~s_axi_awready & ~s_axi_bvalid & s_axi_awvalid & s_axi_wvalid;
			if (wr_en)
				s_axi_bvalid <= 1'b1;
			else if (s_axi_bready)
				s_axi_bvalid <= 1'b0;
		end
	end

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			s_axi_arready <= 1'b0;
			s_axi_rvalid  <= 1'b0;
		end else begin
			s_axi_arready <= ~s_axi_arready & ~s_axi_rvalid & s_axi_arvalid;
			if (rd_en)
				s_axi_rvalid <= 1'b1;
			else if (s_axi_rready)
				s_axi_rvalid <= 1'b0;
		end
	end

	// counters and control.
	// a clearing write beats a same-cycle increment.
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			enable      <= CTRL_ENABLE_RST;
			decoded_cnt <= '0;
			illegal_cnt <= '0;
			last_ill    <= '0;
		end else begin
			if (wr_en && s_axi_awaddr == REG_CTRL && s_axi_wstrb[0])
				enable <= s_axi_wdata[0];
			if (wr_en && s_axi_awaddr == REG_DECODED)
				decoded_cnt <= '0;
			else if (push)
				decoded_cnt <= decoded_cnt + 1'b1;
			if (wr_en && s_axi_awaddr == REG_ILLEGAL)
				illegal_cnt <= '0;
			else if (push && illegal)
				illegal_cnt <= illegal_cnt + 1'b1;
			if (push && illegal)
				last_ill <= instr;
		end
	end

	always_comb begin
		case (s_axi_araddr)
			REG_CTRL:     rd_mux = {{(AXI_DATA_W-1){1'b0}}, enable};
			REG_DECODED:  rd_mux = decoded_cnt;
			REG_ILLEGAL:  rd_mux = illegal_cnt;
			REG_LAST_ILL: rd_mux = {{(AXI_DATA_W-16){1'b0}}, last_ill};
			default:      rd_mux = '0;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (rd_en)
			s_axi_rdata <= rd_mux;
	end

	assign s_axi_bresp = AXI_RESP_OKAY;
	assign s_axi_rresp = AXI_RESP_OKAY;

endmodule

// File: rvc_decode_top.sv
module rvc_decode_top import rvc_pkg::*; (
	input  logic                  CLK,
	input  logic                  rst_n,
	input  logic                  fetch_valid,
	output logic                  fetch_ready,
	input  logic [15:0]           fetch_instr,
	input  logic [XLEN-1:0]       fetch_pc,
	output logic                  uop_valid,
	input  logic                  uop_ready,
	output uop_op_e               uop_op,
	output logic [REG_W-1:0]      uop_rd,
	output logic [REG_W-1:0]      uop_rs1,
	output logic [REG_W-1:0]      uop_rs2,
	output logic [XLEN-1:0]       uop_imm,
	output logic [XLEN-1:0]       uop_pc,
	output logic                  uop_is_rvc,
	input  logic [AXI_ADDR_W-1:0] s_axi_awaddr,
	input  logic                  s_axi_awvalid,
	output logic                  s_axi_awready,
	input  logic [AXI_DATA_W-1:0] s_axi_wdata,
	input  logic [3:0]            s_axi_wstrb,
	input  logic                  s_axi_wvalid,
	output logic                  s_axi_wready,
	output logic [1:0]            s_axi_bresp,
	output logic                  s_axi_bvalid,
	input  logic                  s_axi_bready,
	input  logic [AXI_ADDR_W-1:0] s_axi_araddr,
	input  logic                  s_axi_arvalid,
	output logic                  s_axi_arready,
	output logic [AXI_DATA_W-1:0] s_axi_rdata,
	output logic [1:0]            s_axi_rresp,
	output logic                  s_axi_rvalid,
	input  logic                  s_axi_rready
);

	logic             enable;
	logic             queue_full;
	logic             push;
	logic             illegal;
	uop_op_e          op;
	logic [REG_W-1:0] rd;
	logic [REG_W-1:0] rs1;
	logic [REG_W-1:0] rs2;
	logic [XLEN-1:0]  imm;
	logic [XLEN-1:0]  pc;
	logic             is_rvc;

	rvc_decoder u_decoder (
		.enable      (enable),
		.fetch_valid (fetch_valid),
		.fetch_instr (fetch_instr),
		.fetch_pc    (fetch_pc),
		.fetch_ready (fetch_ready),
		.queue_full  (queue_full),
		.push        (push),
		.illegal     (illegal),
		.op          (op),
		.rd          (rd),
		.rs1         (rs1),
		.rs2         (rs2),
		.imm         (imm),
		.pc          (pc),
		.is_rvc      (is_rvc)
	);

	uop_queue u_queue (
		.CLK        (CLK),
		.rst_n      (rst_n),
		.push       (push),
		.op         (op),
		.rd         (rd),
		.rs1        (rs1),
		.rs2        (rs2),
		.imm        (imm),
		.pc         (pc),
		.is_rvc     (is_rvc),
		.full       (queue_full),
		.uop_valid  (uop_valid),
		.uop_ready  (uop_ready),
		.uop_op     (uop_op),
		.uop_rd     (uop_rd),
		.uop_rs1    (uop_rs1),
		.uop_rs2    (uop_rs2),
		.uop_imm    (uop_imm),
		.uop_pc     (uop_pc),
		.uop_is_rvc (uop_is_rvc)
	);

	// the fetched word is held during the push, so it doubles as the capture source.
	decode_regs u_regs (
		.CLK           (CLK),
		.rst_n         (rst_n),
		.s_axi_awaddr  (s_axi_awaddr),
		.s_axi_awvalid (s_axi_awvalid),
		.s_axi_awready (s_axi_awready),
		.s_axi_wdata   (s_axi_wdata),
		.s_axi_wstrb   (s_axi_wstrb),
		.s_axi_wvalid  (s_axi_wvalid),
		.s_axi_wready  (s_axi_wready),
		.s_axi_bresp   (s_axi_bresp),
		.s_axi_bvalid  (s_axi_bvalid),
		.s_axi_bready  (s_axi_bready),
		.s_axi_araddr  (s_axi_araddr),
		.s_axi_arvalid (s_axi_arvalid),
		.s_axi_arready (s_axi_arready),
		.s_axi_rdata   (s_axi_rdata),
		.s_axi_rresp   (s_axi_rresp),
		.s_axi_rvalid  (s_axi_rvalid),
		.s_axi_rready  (s_axi_rready),
		.push          (push),
		.illegal       (illegal),
		.instr         (fetch_instr),
		.enable        (enable)
	);

endmodule

// File: tb_rvc_decode.sv
module tb_rvc_decode import rvc_pkg::*; ();

	localparam int N_CASES = 24;
	localparam int N_MAIN  = 23;
	localparam int N_ILL   = 4;
	localparam int TIMEOUT = 200;
	localparam logic [XLEN-1:0] PC_BASE = 64'hffff_ffc0_0000_1000;

	logic                  CLK;
	logic                  rst_n;
	logic                  fetch_valid;
	logic                  fetch_ready;
	logic [15:0]           fetch_instr;
	logic [XLEN-1:0]       fetch_pc;
	logic                  uop_valid;
	logic                  uop_ready;
	uop_op_e               uop_op;
	logic [REG_W-1:0]      uop_rd;
	logic [REG_W-1:0]      uop_rs1;
	logic [REG_W-1:0]      uop_rs2;
	logic [XLEN-1:0]       uop_imm;
	logic [XLEN-1:0]       uop_pc;
	logic                  uop_is_rvc;
	logic [AXI_ADDR_W-1:0] s_axi_awaddr;
	logic                  s_axi_awvalid;
	logic                  s_axi_awready;
	logic [AXI_DATA_W-1:0] s_axi_wdata;
	logic [3:0]            s_axi_wstrb;
	logic                  s_axi_wvalid;
	logic                  s_axi_wready;
	logic [1:0]            s_axi_bresp;
	logic                  s_axi_bvalid;
	logic                  s_axi_bready;
	logic [AXI_ADDR_W-1:0] s_axi_araddr;
	logic                  s_axi_arvalid;
	logic                  s_axi_arready;
	logic [AXI_DATA_W-1:0] s_axi_rdata;
	logic [1:0]            s_axi_rresp;
	logic                  s_axi_rvalid;
	logic                  s_axi_rready;

	// instruction table.
	string            name_tab  [N_CASES];
	logic [15:0]      instr_tab [N_CASES];
	logic [XLEN-1:0]  pc_tab    [N_CASES];
	uop_op_e          op_tab    [N_CASES];
	logic [REG_W-1:0] rd_tab    [N_CASES];
	logic [REG_W-1:0] rs1_tab   [N_CASES];
	logic [REG_W-1:0] rs2_tab   [N_CASES];
	logic [XLEN-1:0]  imm_tab   [N_CASES];
	int               n_loaded;

	// table indexes pushed but not yet popped in fetch order.
	int exp_q [$];
	int cur_idx;
	int model_count;
	int full_hits;
	bit drain_en;
	int errors;
	int tests_run;

	rvc_decode_top UUT (.*);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	task automatic add_case(input string name, input logic [15:0] instr, input uop_op_e op,
		input int rd, input int rs1, input int rs2, input logic [XLEN-1:0] imm);
		name_tab[n_loaded]  = name;
		instr_tab[n_loaded] = instr;
		pc_tab[n_loaded]    = PC_BASE + XLEN'(2 * n_loaded);
		op_tab[n_loaded]    = op;
		rd_tab[n_loaded]    = REG_W'(rd);
		rs1_tab[n_loaded]   = REG_W'(rs1);
		rs2_tab[n_loaded]   = REG_W'(rs2);
		imm_tab[n_loaded]   = imm;
		n_loaded++;
	endtask

	// expected fields worked out by hand from the rvc encoding.
	task automatic load_table();
		n_loaded = 0;
		add_case("c.addi4spn x8,520", 16'h0420, OP_ADDI, 8, 2, 0, 64'd520);
		add_case("c.lw x11,68(x10)", 16'h416c, OP_LW, 11, 10, 0, 64'd68);
		add_case("c.ld x9,200(x8)", 16'h6464, OP_LD, 9, 8, 0, 64'd200);
		add_case("c.sw x13,124(x12)", 16'hde74, OP_SW, 0, 12, 13, 64'd124);
		add_case("c.sd x15,72(x14)", 16'he73c, OP_SD, 0, 14, 15, 64'd72);
		add_case("c.addi4spn zero imm", 16'h0008, OP_ILLEGAL, 0, 0, 0, 64'd0);
		add_case("c.addi x5,-3", 16'h12f5, OP_ADDI, 5, 5, 0, -64'sd3);
		add_case("c.li x10,17", 16'h4545, OP_ADDI, 10, 0, 0, 64'd17);
		add_case("c.j +1360", 16'hab81, OP_JAL, 0, 0, 0, 64'd1360);
		add_case("c.j -4", 16'hbff5, OP_JAL, 0, 0, 0, -64'sd4);
		add_case("all-zero word", 16'h0000, OP_ILLEGAL, 0, 0, 0, 64'd0);
		add_case("c.beqz x8,-6", 16'hdc6d, OP_BEQ, 0, 8, 0, -64'sd6);
		add_case("c.bnez x15,42", 16'he78d, OP_BNE, 0, 15, 0, 64'd42);
		add_case("c.fld", 16'h2008, OP_ILLEGAL, 0, 0, 0, 64'd0);
		add_case("c.slli x7,33", 16'h1386, OP_SLLI, 7, 7, 0, 64'd33);
		add_case("c.lwsp x1,228", 16'h509e, OP_LW, 1, 2, 0, 64'd228);
		add_case("c.ldsp x31,424", 16'h7fba, OP_LD, 31, 2, 0, 64'd424);
		add_case("c.swsp x18,148", 16'hcb4a, OP_SW, 0, 2, 18, 64'd148);
		add_case("c.sdsp x9,456", 16'he7a6, OP_SD, 0, 2, 9, 64'd456);
		add_case("c.mv x3,x4", 16'h8192, OP_ADD, 3, 0, 4, 64'd0);
		add_case("c.addiw", 16'h2085, OP_ILLEGAL, 0, 0, 0, 64'd0);
		add_case("c.add x10,x11", 16'h952e, OP_ADD, 10, 10, 11, 64'd0);
		add_case("c.jr x1", 16'h8082, OP_JALR, 0, 1, 0, 64'd0);
		// applied only after decode is enabled again.
		add_case("c.li x6,-1", 16'h537d, OP_ADDI, 6, 0, 0, -64'sd1);
	endtask

	function automatic bit same(input string name, input string field,
		input logic [XLEN-1:0] exp, input logic [XLEN-1:0] act);
		if (act !== exp) begin
			$display("CHECK FAILED %s %s: expected %0h, actual %0h", name, field, exp, act);
			return 1'b0;
		end
		return 1'b1;
	endfunction

	task automatic report_test(input string name, input bit ok);
		tests_run++;
		if (ok) begin
			$display("[pass] %s", name);
		end else begin
			errors++;
		end
	endtask

	// pops about one cycle in three, so the queue fills up.
	initial begin
		void'($urandom(39036));
		uop_ready = 1'b0;
		forever begin
			@(posedge CLK);
			#1;
			uop_ready = drain_en && ($urandom % 3 == 0);
		end
	end

	// queue model sampled where all inputs and outputs are settled.
	always @(negedge CLK) begin
		bit ok;
		int idx;
		if (rst_n) begin
			if (!same("queue occupancy", "uop_valid", 64'(model_count != 0), 64'(uop_valid)))
				errors++;
			if (model_count == QUEUE_DEPTH) begin
				full_hits++;
				if (!same("queue full", "fetch_ready", 64'd0, 64'(fetch_ready)))
					errors++;
			end
			if (uop_valid && uop_ready) begin
				if (exp_q.size() == 0) begin
					$display("a micro-op left the queue with nothing expected");
					errors++;
				end else begin
					idx = exp_q.pop_front();
					ok = same(name_tab[idx], "op", 64'(op_tab[idx]), 64'(uop_op));
					ok &= same(name_tab[idx], "pc", pc_tab[idx], uop_pc);
					ok &= same(name_tab[idx], "is_rvc", 64'd1, 64'(uop_is_rvc));
					// register and immediate fields matter only for legal ops.
					if (op_tab[idx] != OP_ILLEGAL) begin
						ok &= same(name_tab[idx], "rd", 64'(rd_tab[idx]), 64'(uop_rd));
						ok &= same(name_tab[idx], "rs1", 64'(rs1_tab[idx]), 64'(uop_rs1));
						ok &= same(name_tab[idx], "rs2", 64'(rs2_tab[idx]), 64'(uop_rs2));
						ok &= same(name_tab[idx], "imm", imm_tab[idx], uop_imm);
					end
					report_test(name_tab[idx], ok);
				end
				model_count--;
			end
			if (fetch_valid && fetch_ready) begin
				exp_q.push_back(cur_idx);
				model_count++;
			end
		end
	end

	task automatic fetch_one(input int idx);
		int t;
		cur_idx     = idx;
		fetch_valid = 1'b1;
		fetch_instr = instr_tab[idx];
		fetch_pc    = pc_tab[idx];
		t = 0;
		@(negedge CLK);
		while (fetch_ready !== 1'b1 && t < TIMEOUT) begin
			@(negedge CLK);
			t++;
		end
		if (fetch_ready !== 1'b1) begin
			$display("timeout: %s was never accepted by the decoder", name_tab[idx]);
			errors++;
		end
		@(posedge CLK);
		#1;
		fetch_valid = 1'b0;
	endtask

	task automatic wait_drained();
		int t;
		t = 0;
		while ((exp_q.size() != 0 || uop_valid) && t < TIMEOUT) begin
			@(negedge CLK);
			t++;
		end
		if (exp_q.size() != 0) begin
			$display("timeout: %0d micro-ops never left the queue", exp_q.size());
			errors++;
		end
		@(posedge CLK);
		#1;
	endtask

	task automatic axi_write(input logic [AXI_ADDR_W-1:0] addr,
		input logic [AXI_DATA_W-1:0] data);
		int t;
		s_axi_awaddr  = addr;
		s_axi_wdata   = data;
		s_axi_wstrb   = 4'hf;
		s_axi_awvalid = 1'b1;
		s_axi_wvalid  = 1'b1;
		s_axi_bready  = 1'b1;
		t = 0;
		@(negedge CLK);
		while (!(s_axi_awready && s_axi_wready) && t < TIMEOUT) begin
			@(negedge CLK);
			t++;
		end
		if (!(s_axi_awready && s_axi_wready)) begin
			$display("timeout: write to address %0h was never accepted", addr);
			errors++;
		end
		@(posedge CLK);
		#1;
		s_axi_awvalid = 1'b0;
		s_axi_wvalid  = 1'b0;
		t = 0;
		@(negedge CLK);
		while (s_axi_bvalid !== 1'b1 && t < TIMEOUT) begin
			@(negedge CLK);
			t++;
		end
		if (s_axi_bvalid !== 1'b1) begin
			$display("timeout: no write response for address %0h", addr);
			errors++;
		end else if (!same("axi write", "bresp", 64'd0, 64'(s_axi_bresp))) begin
			errors++;
		end
		@(posedge CLK);
		#1;
		s_axi_bready = 1'b0;
	endtask

	task automatic axi_read(input logic [AXI_ADDR_W-1:0] addr,
		output logic [AXI_DATA_W-1:0] data, output logic [1:0] resp);
		int t;
		s_axi_araddr  = addr;
		s_axi_arvalid = 1'b1;
		t = 0;
		@(negedge CLK);
		while (s_axi_arready !== 1'b1 && t < TIMEOUT) begin
			@(negedge CLK);
			t++;
		end
		if (s_axi_arready !== 1'b1) begin
			$display("timeout: read of address %0h was never accepted", addr);
			errors++;
		end
		@(posedge CLK);
		#1;
		s_axi_arvalid = 1'b0;
		s_axi_rready  = 1'b1;
		t = 0;
		@(negedge CLK);
		while (s_axi_rvalid !== 1'b1 && t < TIMEOUT) begin
			@(negedge CLK);
			t++;
		end
		if (s_axi_rvalid !== 1'b1) begin
			$display("timeout: no read data for address %0h", addr);
			errors++;
		end
		data = s_axi_rdata;
		resp = s_axi_rresp;
		@(posedge CLK);
		#1;
		s_axi_rready = 1'b0;
	endtask

	task automatic check_reg(input string name, input logic [AXI_ADDR_W-1:0] addr,
		input logic [AXI_DATA_W-1:0] exp);
		logic [AXI_DATA_W-1:0] data;
		logic [1:0]            resp;
		bit                    ok;
		axi_read(addr, data, resp);
		ok = same(name, "rdata", 64'(exp), 64'(data));
		ok &= same(name, "rresp", 64'd0, 64'(resp));
		report_test(name, ok);
	endtask

	initial begin
		bit ok;
		rst_n         = 1'b0;
		fetch_valid   = 1'b0;
		fetch_instr   = '0;
		fetch_pc      = '0;
		s_axi_awaddr  = '0;
		s_axi_awvalid = 1'b0;
		s_axi_wdata   = '0;
		s_axi_wstrb   = '0;
		s_axi_wvalid  = 1'b0;
		s_axi_bready  = 1'b0;
		s_axi_araddr  = '0;
		s_axi_arvalid = 1'b0;
		s_axi_rready  = 1'b0;
		drain_en      = 1'b0;
		cur_idx       = 0;
		model_count   = 0;
		full_hits     = 0;
		errors        = 0;
		tests_run     = 0;
		load_table();
		repeat (5) @(posedge CLK);
		#1;
		rst_n = 1'b1;

		// reset state.
		@(negedge CLK);
		ok = same("reset handshake", "uop_valid", 64'd0, 64'(uop_valid));
		ok &= same("reset handshake", "fetch_ready", 64'd1, 64'(fetch_ready));
		report_test("reset handshake", ok);
		@(posedge CLK);
		#1;
		check_reg("reset ctrl", REG_CTRL, 32'd1);
		check_reg("reset decoded count", REG_DECODED, 32'd0);
		check_reg("reset illegal count", REG_ILLEGAL, 32'd0);
		check_reg("reset last illegal", REG_LAST_ILL, 32'd0);

		// table run under random back-pressure.
		drain_en = 1'b1;
		for (int i = 0; i < N_MAIN; i++)
			fetch_one(i);
		wait_drained();
		drain_en = 1'b0;
		if (full_hits == 0) begin
			$display("the queue never filled during the table run");
			errors++;
		end

		check_reg("decoded count", REG_DECODED, 32'(N_MAIN));
		check_reg("illegal count", REG_ILLEGAL, 32'(N_ILL));
		check_reg("last illegal", REG_LAST_ILL, 32'h2085);

		// clear, disable, then enable with a held fetch.
		axi_write(REG_DECODED, 32'hdead_beef);
		check_reg("decoded count cleared", REG_DECODED, 32'd0);
		axi_write(REG_CTRL, 32'd0);
		cur_idx     = N_MAIN;
		fetch_valid = 1'b1;
		fetch_instr = instr_tab[N_MAIN];
		fetch_pc    = pc_tab[N_MAIN];
		ok = 1'b1;
		repeat (4) begin
			@(negedge CLK);
			ok &= same("decode disabled", "fetch_ready", 64'd0, 64'(fetch_ready));
			ok &= same("decode disabled", "uop_valid", 64'd0, 64'(uop_valid));
		end
		report_test("decode disabled", ok);
		@(posedge CLK);
		#1;
		drain_en = 1'b1;
		fork
			axi_write(REG_CTRL, 32'd1);
			fetch_one(N_MAIN);
		join
		wait_drained();
		drain_en = 1'b0;
		check_reg("decoded count after enable", REG_DECODED, 32'd1);

		$display("%0d tests run, %0d errors", tests_run, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// File: flist.f
rvc_pkg.sv
rvc_decoder.sv
uop_queue.sv
decode_regs.sv
rvc_decode_top.sv
tb_rvc_decode.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_rvc_decode
FLIST     := flist.f
OBJ_DIR   := obj_dir
PASS_MSG  := all tests passed

SRCS := $(shell grep -v '^+' $(FLIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	$(SIM) | tee /dev/stderr | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
